//--- rtl/matrix_decode_pkg.sv
// Shared definitions for the AHB matrix decoder stage
//   Port count and decode address width
//   Port code enum with default slave code
//   HTRANS and HRESP codes
//   Address map bounds per output port

`default_nettype none

package matrix_decode_pkg;

    //----------------------------------------------------------------------
    // Widths
    //----------------------------------------------------------------------

    localparam int NUM_PORTS = 7;                 // Output ports MI0..MI6

    typedef logic [21:0] decode_addr_t;           // HADDR[31:10]
    typedef logic [NUM_PORTS-1:0] port_vec_t;     // One bit per output port
    typedef logic [1:0] trans_t;                  // HTRANS
    typedef logic [1:0] resp_t;                   // HRESP
    typedef logic [2*NUM_PORTS-1:0] resp_vec_t;   // Port N in bits 2N+1:2N

    // Destination of a transfer
    typedef enum logic [2:0] {
        PORT_MI0     = 3'd0,
        PORT_MI1     = 3'd1,
        PORT_MI2     = 3'd2,
        PORT_MI3     = 3'd3,
        PORT_MI4     = 3'd4,
        PORT_MI5     = 3'd5,
        PORT_MI6     = 3'd6,
        PORT_DFT_SLV = 3'd7                        // Unmapped address
    } port_code_t;

    //----------------------------------------------------------------------
    // AHB codes
    //----------------------------------------------------------------------

    localparam trans_t TRANS_IDLE   = 2'b00;
    localparam trans_t TRANS_BUSY   = 2'b01;
    localparam trans_t TRANS_NONSEQ = 2'b10;
    localparam trans_t TRANS_SEQ    = 2'b11;

    localparam resp_t RESP_OKAY  = 2'b00;
    localparam resp_t RESP_ERROR = 2'b01;

    //----------------------------------------------------------------------
    // Address map, inclusive bounds on HADDR[31:10]
    //----------------------------------------------------------------------

    // Byte address / 1 KB gives the 22-bit value
    localparam decode_addr_t ADDR_LO [NUM_PORTS] = '{
        22'h000000,                                // 0x00000000
        22'h080000,                                // 0x20000000
        22'h100000,                                // 0x40000000
        22'h100040,                                // 0x40010000
        22'h100044,                                // 0x40011000
        22'h100020,                                // 0x40008000
        22'h100080                                 // 0x40020000
    };

    localparam decode_addr_t ADDR_HI [NUM_PORTS] = '{
        22'h0003FF,                                // 0x000FFFFF
        22'h0803FF,                                // 0x200FFFFF
        22'h100017,                                // 0x40005FFF
        22'h100043,                                // 0x40010FFF
        22'h100057,                                // 0x40015FFF
        22'h100020,                                // 0x400083FF
        22'h100081                                 // 0x400207FF
    };

endpackage

`default_nettype wire

//--- rtl/addr_phase_decode.sv
// Address phase side of the matrix decoder
//   Region compare against the address map
//   Priority walk with idle hold to the data-phase port
//   One-hot selects for output ports and default slave
//   Active flag mux for the decoded port

`timescale 1ns/1ps
`default_nettype none

module addr_phase_decode (
    input  wire                                 sel_dec,          // HSEL from input stage
    input  wire matrix_decode_pkg::decode_addr_t decode_addr_dec, // HADDR[31:10]
    input  wire matrix_decode_pkg::trans_t      trans_dec,        // HTRANS
    input  wire matrix_decode_pkg::port_code_t  data_out_port,    // Current data-phase owner
    input  wire matrix_decode_pkg::port_vec_t   active_ports,     // Output stage active flags
    output matrix_decode_pkg::port_code_t       addr_out_port,    // Decoded destination
    output matrix_decode_pkg::port_vec_t        sel_ports,        // HSEL to output stages
    output logic                                sel_dft_slv,      // HSEL to default slave
    output logic                                active_dec        // Active flag of destination
);

    //----------------------------------------------------------------------
    // Region match
    //----------------------------------------------------------------------

    matrix_decode_pkg::port_vec_t region_hit;     // Address inside region N
    matrix_decode_pkg::port_vec_t hold_hit;       // IDLE keeps port N
    matrix_decode_pkg::port_vec_t port_hit;       // Either reason

    logic idle_xfer;

    assign idle_xfer = (trans_dec == matrix_decode_pkg::TRANS_IDLE);

    always_comb
    begin
        for (int n = 0; n < matrix_decode_pkg::NUM_PORTS; n++)
        begin
            region_hit[n] = (decode_addr_dec >= matrix_decode_pkg::ADDR_LO[n]) &&
                            (decode_addr_dec <= matrix_decode_pkg::ADDR_HI[n]);
            // IDLE stays with the port that owns the data phase
            hold_hit[n]   = idle_xfer &&
                            (data_out_port == matrix_decode_pkg::port_code_t'(n));
        end
    end

    assign port_hit = region_hit | hold_hit;

    //----------------------------------------------------------------------
    // Priority walk
    //----------------------------------------------------------------------

    // Lowest port number wins, so walk from the top down
    always_comb
    begin
        addr_out_port = matrix_decode_pkg::PORT_DFT_SLV;  // Nothing matched
        for (int n = matrix_decode_pkg::NUM_PORTS - 1; n >= 0; n--)
        begin
            if (port_hit[n])
                addr_out_port = matrix_decode_pkg::port_code_t'(n);
        end
    end

    //----------------------------------------------------------------------
    // Selects and active flag
    //----------------------------------------------------------------------

    // Bit 7 stands for the default slave, matching its port code
    logic [matrix_decode_pkg::NUM_PORTS:0] dest_sel;
    logic [matrix_decode_pkg::NUM_PORTS:0] dest_active;

    always_comb
    begin
        dest_sel = '0;
        if (sel_dec)
            dest_sel[addr_out_port] = 1'b1;       // One-hot on destination
    end

    assign sel_ports   = dest_sel[matrix_decode_pkg::NUM_PORTS-1:0];
    assign sel_dft_slv = dest_sel[matrix_decode_pkg::NUM_PORTS];

    // Default slave is always free
    assign dest_active = {1'b1, active_ports};
    assign active_dec  = dest_active[addr_out_port];

endmodule

`default_nettype wire

//--- rtl/default_slave.sv
// Default slave for unmapped addresses
//   Three-state FSM for the two-cycle ERROR response
//   Zero-wait OKAY for IDLE and BUSY

`timescale 1ns/1ps
`default_nettype none

module default_slave (
    input  wire                            HCLK,
    input  wire                            HRESETn,          // Sync, active low
    input  wire                            sel_dft_slv,      // HSEL from decoder
    input  wire                            HREADYS,          // Transfer done
    input  wire matrix_decode_pkg::trans_t trans_dec,        // HTRANS
    output logic                           readyout_dft_slv, // HREADYOUT
    output matrix_decode_pkg::resp_t       resp_dft_slv      // HRESP
);

    typedef enum logic [1:0] {
        DFT_IDLE = 2'd0,                          // OKAY, ready
        DFT_ERR1 = 2'd1,                          // ERROR, wait
        DFT_ERR2 = 2'd2                           // ERROR, ready
    } dft_state_t;

    dft_state_t state;
    dft_state_t state_nxt;

    logic real_xfer;                              // NONSEQ or SEQ on the bus
    logic err_req;                                // Transfer needs an ERROR

    always_comb
    begin
        case (trans_dec)
            matrix_decode_pkg::TRANS_NONSEQ,
            matrix_decode_pkg::TRANS_SEQ  : real_xfer = 1'b1;
            matrix_decode_pkg::TRANS_IDLE,
            matrix_decode_pkg::TRANS_BUSY : real_xfer = 1'b0;
            default                       : real_xfer = 1'b0;
        endcase
    end

    assign err_req = HREADYS & sel_dft_slv & real_xfer;

    //----------------------------------------------------------------------
    // State machine
    //----------------------------------------------------------------------

    always_comb
    begin
        case (state)
            DFT_IDLE : state_nxt = err_req ? DFT_ERR1 : DFT_IDLE;
            DFT_ERR1 : state_nxt = DFT_ERR2;      // Second cycle always follows
            DFT_ERR2 : state_nxt = err_req ? DFT_ERR1 : DFT_IDLE;
            default  : state_nxt = DFT_IDLE;
        endcase
    end

    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
            state <= DFT_IDLE;
        else
            state <= state_nxt;
    end

    // Wait only in the first error cycle
    assign readyout_dft_slv = (state != DFT_ERR1);
    assign resp_dft_slv     = (state == DFT_IDLE) ? matrix_decode_pkg::RESP_OKAY
                                                  : matrix_decode_pkg::RESP_ERROR;

endmodule

`default_nettype wire

//--- rtl/data_phase_mux.sv
// Data phase side of the matrix decoder
//   Data-phase owner register loaded on HREADYS
//   Ready, response and read data muxes
//   Default slave substituted with zero read data

`timescale 1ns/1ps
`default_nettype none

module data_phase_mux #(
    parameter int DATA_W = 32                     // Read data width
) (
    input  wire                                HCLK,
    input  wire                                HRESETn,          // Sync, active low
    input  wire                                HREADYS,          // Transfer done
    input  wire matrix_decode_pkg::port_code_t addr_out_port,    // Address-phase destination
    input  wire matrix_decode_pkg::port_vec_t  readyout_ports,   // HREADYOUT per port
    input  wire matrix_decode_pkg::resp_vec_t  resp_ports,       // HRESP per port
    input  wire [matrix_decode_pkg::NUM_PORTS-1:0][DATA_W-1:0] rdata_ports, // HRDATA per port
    input  wire                                readyout_dft_slv, // Default slave HREADYOUT
    input  wire matrix_decode_pkg::resp_t      resp_dft_slv,     // Default slave HRESP
    output matrix_decode_pkg::port_code_t      data_out_port,    // Data-phase owner
    output logic                               HREADYOUTS,       // HREADY feedback
    output matrix_decode_pkg::resp_t           HRESPS,           // Transfer response
    output logic [DATA_W-1:0]                  HRDATAS           // Read data
);

    //----------------------------------------------------------------------
    // Data-phase owner
    //----------------------------------------------------------------------

    // HREADYS rather than our own HREADYOUTS decides when the
    // address phase is over
    always_ff @(posedge HCLK)
    begin
        if (!HRESETn)
            data_out_port <= matrix_decode_pkg::PORT_MI0;
        else if (HREADYS)
            data_out_port <= addr_out_port;       // Holds while stalled
    end

    //----------------------------------------------------------------------
    // Return path muxes
    //----------------------------------------------------------------------

    // Top entry of each table is the default slave
    logic [matrix_decode_pkg::NUM_PORTS:0]                   ready_all;
    matrix_decode_pkg::resp_t [matrix_decode_pkg::NUM_PORTS:0] resp_all;
    logic [matrix_decode_pkg::NUM_PORTS:0][DATA_W-1:0]       rdata_all;

    assign ready_all = {readyout_dft_slv, readyout_ports};
    assign resp_all  = {resp_dft_slv, resp_ports};
    assign rdata_all = {{DATA_W{1'b0}}, rdata_ports};      // No read data from default slave

    assign HREADYOUTS = ready_all[data_out_port];
    assign HRESPS     = resp_all[data_out_port];
    assign HRDATAS    = rdata_all[data_out_port];

endmodule

`default_nettype wire

//--- rtl/matrix_decode.sv
// Top of the AHB matrix decoder stage for one input port
//   Address phase decode and select generation
//   Default slave for unmapped addresses
//   Data phase owner register and return muxes

`timescale 1ns/1ps
`default_nettype none

module matrix_decode #(
    parameter int DATA_W = 32                     // Read data width
) (
    // Clock and reset
    input  wire                                  HCLK,
    input  wire                                  HRESETn,         // Sync, active low

    // From input stage
    input  wire                                  HREADYS,         // Transfer done
    input  wire                                  sel_dec,         // HSEL
    input  wire matrix_decode_pkg::decode_addr_t decode_addr_dec, // HADDR[31:10]
    input  wire matrix_decode_pkg::trans_t       trans_dec,       // HTRANS

    // From output stages
    input  wire matrix_decode_pkg::port_vec_t    active_ports,
    input  wire matrix_decode_pkg::port_vec_t    readyout_ports,
    input  wire matrix_decode_pkg::resp_vec_t    resp_ports,
    input  wire [matrix_decode_pkg::NUM_PORTS-1:0][DATA_W-1:0] rdata_ports,

    // To output stages
    output matrix_decode_pkg::port_vec_t         sel_ports,       // HSEL per port

    // To input stage
    output logic                                 active_dec,
    output logic                                 HREADYOUTS,
    output matrix_decode_pkg::resp_t             HRESPS,
    output logic [DATA_W-1:0]                    HRDATAS
);

    matrix_decode_pkg::port_code_t addr_out_port; // Address-phase destination
    matrix_decode_pkg::port_code_t data_out_port; // Data-phase owner
    logic                          sel_dft_slv;
    logic                          readyout_dft_slv;
    matrix_decode_pkg::resp_t      resp_dft_slv;

    //----------------------------------------------------------------------
    // Address phase
    //----------------------------------------------------------------------

    addr_phase_decode u_addr_phase_decode (
        .sel_dec         (sel_dec),
        .decode_addr_dec (decode_addr_dec),
        .trans_dec       (trans_dec),
        .data_out_port   (data_out_port),         // Needed for idle hold
        .active_ports    (active_ports),
        .addr_out_port   (addr_out_port),
        .sel_ports       (sel_ports),
        .sel_dft_slv     (sel_dft_slv),
        .active_dec      (active_dec)
    );

    // Answers unmapped transfers
    default_slave u_default_slave (
        .HCLK             (HCLK),
        .HRESETn          (HRESETn),
        .sel_dft_slv      (sel_dft_slv),
        .HREADYS          (HREADYS),
        .trans_dec        (trans_dec),
        .readyout_dft_slv (readyout_dft_slv),
        .resp_dft_slv     (resp_dft_slv)
    );

    //----------------------------------------------------------------------
    // Data phase
    //----------------------------------------------------------------------

    data_phase_mux #(
        .DATA_W (DATA_W)
    ) u_data_phase_mux (
        .HCLK             (HCLK),
        .HRESETn          (HRESETn),
        .HREADYS          (HREADYS),
        .addr_out_port    (addr_out_port),
        .readyout_ports   (readyout_ports),
        .resp_ports       (resp_ports),
        .rdata_ports      (rdata_ports),
        .readyout_dft_slv (readyout_dft_slv),
        .resp_dft_slv     (resp_dft_slv),
        .data_out_port    (data_out_port),
        .HREADYOUTS       (HREADYOUTS),
        .HRESPS           (HRESPS),
        .HRDATAS          (HRDATAS)
    );

endmodule

`default_nettype wire

//--- testbench/tb_matrix_decode.sv
// Self-checking testbench for the AHB matrix decoder stage
//   LFSR stimulus with region bounds and random addresses
//   Reference decode, select and active functions
//   Shadow data-phase owner and default slave state
//   Compare tasks per result type and a watchdog

`timescale 1ns/1ps
`default_nettype none

module tb_matrix_decode;

    localparam int DATA_W          = 32;
    localparam int RAND_CYCLES     = 400;
    localparam int DIRECTED_CYCLES = 64;                       // Upper bound of directed part
    localparam int TEST_CYCLES     = DIRECTED_CYCLES + RAND_CYCLES;
    localparam int WATCHDOG_NS     = (16 + TEST_CYCLES + 100) * 4;
    localparam logic [15:0] SEED   = 16'd57976;

    // Byte address map, inclusive bounds
    localparam logic [31:0] REGION_LO [0:6] = '{32'h0000_0000, 32'h2000_0000,
        32'h4000_0000, 32'h4001_0000, 32'h4001_1000, 32'h4000_8000, 32'h4002_0000};
    localparam logic [31:0] REGION_HI [0:6] = '{32'h000F_FFFF, 32'h200F_FFFF,
        32'h4000_5FFF, 32'h4001_0FFF, 32'h4001_5FFF, 32'h4000_83FF, 32'h4002_07FF};

    // Shadow default slave states
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ERR1 = 2'd1;
    localparam logic [1:0] ST_ERR2 = 2'd2;

    logic                                  HCLK = 1'b0;
    logic                                  HRESETn;
    logic                                  HREADYS;
    logic                                  sel_dec;
    logic [31:0]                           haddr;             // Full byte address
    matrix_decode_pkg::decode_addr_t       decode_addr_dec;
    matrix_decode_pkg::trans_t             trans_dec;
    matrix_decode_pkg::port_vec_t          active_ports;
    matrix_decode_pkg::port_vec_t          readyout_ports;
    matrix_decode_pkg::resp_vec_t          resp_ports;
    logic [matrix_decode_pkg::NUM_PORTS-1:0][DATA_W-1:0] rdata_ports;
    matrix_decode_pkg::port_vec_t          sel_ports;
    logic                                  active_dec;
    logic                                  HREADYOUTS;
    matrix_decode_pkg::resp_t              HRESPS;
    logic [DATA_W-1:0]                     HRDATAS;

    logic [15:0]                           lfsr_state;
    matrix_decode_pkg::port_code_t         shadow_port;       // Expected data-phase owner
    logic [1:0]                            shadow_dft;        // Expected default slave state
    matrix_decode_pkg::port_code_t         exp_addr_port;
    logic                                  exp_err_req;
    int                                    check_count = 0;

    assign decode_addr_dec = haddr[31:10];

    matrix_decode #(
        .DATA_W (DATA_W)
    ) u_matrix_decode (
        .HCLK            (HCLK),
        .HRESETn         (HRESETn),
        .HREADYS         (HREADYS),
        .sel_dec         (sel_dec),
        .decode_addr_dec (decode_addr_dec),
        .trans_dec       (trans_dec),
        .active_ports    (active_ports),
        .readyout_ports  (readyout_ports),
        .resp_ports      (resp_ports),
        .rdata_ports     (rdata_ports),
        .sel_ports       (sel_ports),
        .active_dec      (active_dec),
        .HREADYOUTS      (HREADYOUTS),
        .HRESPS          (HRESPS),
        .HRDATAS         (HRDATAS)
    );

    always #2 HCLK = ~HCLK;                                    // 4 ns period

    //----------------------------------------------------------------------
    // Random source
    //----------------------------------------------------------------------

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int width, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < width; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};       // One step per bit
        end
    endtask

    // Region bounds, one past the top, or anything
    task automatic pick_address(output logic [31:0] addr);
        logic [31:0] r;
        int          region;
        random_bits(3, r);
        region = int'(r[2:0]) % 7;
        random_bits(2, r);
        case (r[1:0])
            2'd0    : addr = REGION_LO[region];
            2'd1    : addr = REGION_HI[region];
            2'd2    : addr = REGION_HI[region] + 32'd1;
            default : random_bits(32, addr);
        endcase
    endtask

    task automatic shuffle_slaves();
        logic [31:0] r;
        random_bits(7, r);
        active_ports = r[6:0];
        random_bits(7, r);
        readyout_ports = r[6:0];
        random_bits(14, r);
        resp_ports = r[13:0];
        for (int p = 0; p < matrix_decode_pkg::NUM_PORTS; p++)
        begin
            random_bits(DATA_W, r);
            rdata_ports[p] = r;
        end
    endtask

    //----------------------------------------------------------------------
    // Reference model
    //----------------------------------------------------------------------

    // Lowest port wins, address match or IDLE hold on the owner
    function automatic matrix_decode_pkg::port_code_t decode_port(
        input logic [31:0] addr, input matrix_decode_pkg::trans_t trans,
        input matrix_decode_pkg::port_code_t owner);
        matrix_decode_pkg::port_code_t code;
        logic                          idle_hold;
        code = matrix_decode_pkg::PORT_DFT_SLV;
        for (int n = 6; n >= 0; n--)
        begin
            idle_hold = (trans == matrix_decode_pkg::TRANS_IDLE) && (int'(owner) == n);
            if ((addr >= REGION_LO[n] && addr <= REGION_HI[n]) || idle_hold)
                code = matrix_decode_pkg::port_code_t'(n);
        end
        return code;
    endfunction

    function automatic matrix_decode_pkg::port_vec_t expected_selects(
        input logic sel, input matrix_decode_pkg::port_code_t code);
        matrix_decode_pkg::port_vec_t vec;
        vec = '0;
        if (sel && code != matrix_decode_pkg::PORT_DFT_SLV)
            vec[int'(code)] = 1'b1;
        return vec;
    endfunction

    function automatic logic expected_active(input matrix_decode_pkg::port_code_t code,
        input matrix_decode_pkg::port_vec_t act);
        if (code == matrix_decode_pkg::PORT_DFT_SLV)
            return 1'b1;                                     // Default slave never busy
        return act[int'(code)];
    endfunction

    assign exp_addr_port = decode_port(haddr, trans_dec, shadow_port);
    assign exp_err_req   = HREADYS && sel_dec &&
                           (exp_addr_port == matrix_decode_pkg::PORT_DFT_SLV) &&
                           (trans_dec == matrix_decode_pkg::TRANS_NONSEQ ||
                            trans_dec == matrix_decode_pkg::TRANS_SEQ);

    always @(posedge HCLK)
    begin
        if (!HRESETn)
        begin
            shadow_port <= matrix_decode_pkg::PORT_MI0;
            shadow_dft  <= ST_IDLE;
        end
        else
        begin
            if (HREADYS)
                shadow_port <= exp_addr_port;              // Address phase done
            case (shadow_dft)
                ST_ERR1 : shadow_dft <= ST_ERR2;
                default : shadow_dft <= exp_err_req ? ST_ERR1 : ST_IDLE;
            endcase
        end
    end

    //----------------------------------------------------------------------
    // Compare tasks
    //----------------------------------------------------------------------

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_sel(input string name, input matrix_decode_pkg::port_vec_t exp_val,
        input matrix_decode_pkg::port_vec_t act_val);
        if (act_val !== exp_val)
        begin
            $display("ERR t=%0t %s expected=%b actual=%b", $time, name, exp_val, act_val);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val)
        begin
            $display("ERR t=%0t %s expected=%b actual=%b", $time, name, exp_val, act_val);
            stop_with_failure();
        end
    endtask

    task automatic check_resp(input string name, input matrix_decode_pkg::resp_t exp_val,
        input matrix_decode_pkg::resp_t act_val);
        if (act_val !== exp_val)
        begin
            $display("ERR t=%0t %s expected=%h actual=%h", $time, name, exp_val, act_val);
            stop_with_failure();
        end
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] exp_val,
        input logic [DATA_W-1:0] act_val);
        if (act_val !== exp_val)
        begin
            $display("ERR t=%0t %s expected=%h actual=%h", $time, name, exp_val, act_val);
            stop_with_failure();
        end
    endtask

    task automatic compare_outputs();
        logic                     exp_ready;
        matrix_decode_pkg::resp_t exp_resp;
        logic [DATA_W-1:0]        exp_data;
        int                       owner;
        check_sel("sel_ports", expected_selects(sel_dec, exp_addr_port), sel_ports);
        check_bit("active_dec", expected_active(exp_addr_port, active_ports), active_dec);
        if (shadow_port == matrix_decode_pkg::PORT_DFT_SLV)
        begin
            exp_ready = (shadow_dft != ST_ERR1);             // Wait only in first cycle
            exp_resp  = (shadow_dft == ST_IDLE) ? matrix_decode_pkg::RESP_OKAY
                                                : matrix_decode_pkg::RESP_ERROR;
            exp_data  = '0;
        end
        else
        begin
            owner     = int'(shadow_port);
            exp_ready = readyout_ports[owner];
            exp_resp  = resp_ports[2*owner +: 2];
            exp_data  = rdata_ports[owner];
        end
        check_bit("HREADYOUTS", exp_ready, HREADYOUTS);
        check_resp("HRESPS", exp_resp, HRESPS);
        check_data("HRDATAS", exp_data, HRDATAS);
        check_count++;
    endtask

    // 1 ns before each rising edge
    initial
    begin
        forever
        begin
            @(negedge HCLK);
            #1;
            if (HRESETn)
                compare_outputs();
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        stop_with_failure();
    end

    //----------------------------------------------------------------------
    // Stimulus
    //----------------------------------------------------------------------

    task automatic drive_cycle(input logic sel, input logic [31:0] addr,
        input matrix_decode_pkg::trans_t trans, input logic ready, input logic vary);
        @(negedge HCLK);
        sel_dec   = sel;
        haddr     = addr;
        trans_dec = trans;
        HREADYS   = ready;
        if (vary)
            shuffle_slaves();
    endtask

    task automatic random_cycle();
        logic [31:0]               r;
        logic [31:0]               addr;
        logic                      sel;
        logic                      ready;
        matrix_decode_pkg::trans_t trans;
        random_bits(2, r);
        sel = (r[1:0] != 2'b00);                             // Mostly selected
        random_bits(2, r);
        ready = (r[1:0] != 2'b00);                           // Some stalls
        random_bits(2, r);
        trans = r[1:0];
        pick_address(addr);
        drive_cycle(sel, addr, trans, ready, 1'b1);
    endtask

    initial
    begin
        logic [31:0] r;
        lfsr_state     = SEED;
        HRESETn        = 1'b0;
        HREADYS        = 1'b1;
        sel_dec        = 1'b0;
        haddr          = '0;
        trans_dec      = matrix_decode_pkg::TRANS_IDLE;
        active_ports   = '0;
        readyout_ports = '1;                                 // Port 0 ready, OKAY
        resp_ports     = '0;
        for (int p = 0; p < matrix_decode_pkg::NUM_PORTS; p++)
        begin
            random_bits(DATA_W, r);
            rdata_ports[p] = r;
        end
        repeat (16) @(negedge HCLK);
        HRESETn = 1'b1;

        // Reset state, deselected
        repeat (4) drive_cycle(1'b0, 32'h0, matrix_decode_pkg::TRANS_IDLE, 1'b1, 1'b0);

        // Region bounds and just outside
        for (int n = 0; n < matrix_decode_pkg::NUM_PORTS; n++)
        begin
            drive_cycle(1'b1, REGION_LO[n], matrix_decode_pkg::TRANS_NONSEQ, 1'b1, 1'b1);
            drive_cycle(1'b1, REGION_HI[n], matrix_decode_pkg::TRANS_NONSEQ, 1'b1, 1'b1);
            drive_cycle(1'b1, REGION_LO[n] - 32'd1, matrix_decode_pkg::TRANS_NONSEQ, 1'b1, 1'b1);
            drive_cycle(1'b1, REGION_HI[n] + 32'd1, matrix_decode_pkg::TRANS_NONSEQ, 1'b1, 1'b1);
        end

        // Idle hold on owner unless a lower region matches
        drive_cycle(1'b1, 32'h4001_0400, matrix_decode_pkg::TRANS_NONSEQ, 1'b1, 1'b1);
        drive_cycle(1'b1, 32'h9000_0000, matrix_decode_pkg::TRANS_IDLE, 1'b1, 1'b1);
        drive_cycle(1'b1, 32'h9000_0000, matrix_decode_pkg::TRANS_IDLE, 1'b1, 1'b1);
        drive_cycle(1'b1, 32'h4000_8000, matrix_decode_pkg::TRANS_NONSEQ, 1'b1, 1'b1);
        drive_cycle(1'b1, 32'h2000_1000, matrix_decode_pkg::TRANS_IDLE, 1'b1, 1'b1);
        drive_cycle(1'b1, 32'h4002_0000, matrix_decode_pkg::TRANS_IDLE, 1'b1, 1'b1);
        drive_cycle(1'b1, 32'h0000_0000, matrix_decode_pkg::TRANS_IDLE, 1'b1, 1'b1);

        // Owner frozen while HREADYS low
        drive_cycle(1'b1, 32'h4001_2000, matrix_decode_pkg::TRANS_NONSEQ, 1'b1, 1'b1);
        drive_cycle(1'b1, 32'h2000_0000, matrix_decode_pkg::TRANS_NONSEQ, 1'b0, 1'b1);
        drive_cycle(1'b1, 32'h2000_0000, matrix_decode_pkg::TRANS_NONSEQ, 1'b0, 1'b1);
        drive_cycle(1'b1, 32'h2000_0000, matrix_decode_pkg::TRANS_NONSEQ, 1'b1, 1'b1);
        drive_cycle(1'b0, 32'h0000_0000, matrix_decode_pkg::TRANS_IDLE, 1'b1, 1'b1);

        // Default slave, two-cycle ERROR then OKAY for IDLE and BUSY
        drive_cycle(1'b1, 32'h8000_0000, matrix_decode_pkg::TRANS_NONSEQ, 1'b1, 1'b1);
        drive_cycle(1'b1, 32'h8000_0000, matrix_decode_pkg::TRANS_IDLE, 1'b1, 1'b1);
        drive_cycle(1'b1, 32'h8000_0000, matrix_decode_pkg::TRANS_IDLE, 1'b1, 1'b1);
        drive_cycle(1'b1, 32'h8000_0400, matrix_decode_pkg::TRANS_SEQ, 1'b1, 1'b1);
        drive_cycle(1'b1, 32'h8000_0400, matrix_decode_pkg::TRANS_BUSY, 1'b0, 1'b1);
        drive_cycle(1'b1, 32'h8000_0400, matrix_decode_pkg::TRANS_BUSY, 1'b1, 1'b1);
        drive_cycle(1'b1, 32'h8000_0400, matrix_decode_pkg::TRANS_IDLE, 1'b1, 1'b1);

        for (int i = 0; i < RAND_CYCLES; i++)
            random_cycle();

        drive_cycle(1'b0, 32'h0, matrix_decode_pkg::TRANS_IDLE, 1'b1, 1'b0);
        @(negedge HCLK);
        #2;                                                  // Last data phase checked
        $display("%0d cycles compared", check_count);
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
rtl/matrix_decode_pkg.sv
rtl/addr_phase_decode.sv
rtl/default_slave.sv
rtl/data_phase_mux.sv
rtl/matrix_decode.sv
testbench/tb_matrix_decode.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the matrix decoder testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_matrix_decode \
    -o tb_matrix_decode

# Keep the output even when the simulation stops with an error
output=$(./obj_dir/tb_matrix_decode 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "All tests passed"; then
    echo "Result: PASS"
else
    echo "Result: FAIL"
    exit 1
fi
